/* common/periph_settings.svh */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Bus geometry
`define DATA_WIDTH 16
`define ADDR_WIDTH 4

// Wide enough for the divide-by-8192 enable
`define PRESCALE_WIDTH 13

// Interval timer write keys in the upper byte
`define TCNT_KEY 8'h5A
`define TCSR_KEY 8'hA5

// Block codes in the upper two address bits
`define TIMER_BLOCK 2'd0
`define WDT_BLOCK   2'd2
`define INTC_BLOCK  2'd3

// Register word offsets
`define FRC_ADDR   4'd0
`define OCRA_ADDR  4'd1
`define FTCSR_ADDR 4'd2
`define TCR_ADDR   4'd3
`define WTCNT_ADDR 4'd8
`define WTCSR_ADDR 4'd9
`define IPR_ADDR   4'd12
`define VCR_ADDR   4'd13
`define VCRW_ADDR  4'd14

`endif

/* common/periphBusPkg.sv */
`include "periph_settings.svh"

package periphBusPkg;

	// One word on the peripheral bus
	typedef logic [`DATA_WIDTH-1:0] busWord_t;

	// Word address, upper two bits pick the block
	typedef logic [`ADDR_WIDTH-1:0] busAddr_t;

	// Interval timer registers are written as key and value
	typedef union packed {
		busWord_t raw;
		struct packed {
			logic [7:0] key;
			logic [7:0] value;
		} field;
	} keyedWrite_t;

endpackage

/* common/irqPkg.sv */
package irqPkg;

	// Level 0 means no request
	typedef logic [3:0] irqLevel_t;

	// Programmable part of a vector number
	typedef logic [6:0] vectorCode_t;

	// Full vector number with bit 7 held at zero
	typedef logic [7:0] irqVector_t;

endpackage

/* logic/clockPrescaler.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module clockPrescaler (
	input  logic CLK,
	input  logic RST_N,
	output logic tick8,
	output logic tick32,
	output logic tick64,
	output logic tick128,
	output logic tick256,
	output logic tick512,
	output logic tick1024,
	output logic tick4096,
	output logic tick8192
);

	logic [`PRESCALE_WIDTH-1:0] divCount;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	// One pulse every 2^n cycles when the low n bits are all ones
	assign tick8    = &divCount[2:0];
	assign tick32   = &divCount[4:0];
	assign tick64   = &divCount[5:0];
	assign tick128  = &divCount[6:0];
	assign tick256  = &divCount[7:0];
	assign tick512  = &divCount[8:0];
	assign tick1024 = &divCount[9:0];
	assign tick4096 = &divCount[11:0];
	assign tick8192 = &divCount[12:0];

endmodule

/* timer/freeRunTimer.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module freeRunTimer (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   writeEn,
	input  periphBusPkg::busAddr_t regAddr,
	input  periphBusPkg::busWord_t writeData,
	output periphBusPkg::busWord_t readData,
	input  logic                   tick8,
	input  logic                   tick32,
	input  logic                   tick128,
	output logic                   compareIrq,
	output logic                   overflowIrq
);

	periphBusPkg::busWord_t frc;
	periphBusPkg::busWord_t ocra;

	// TCR fields
	logic [1:0] clockSel;
	logic       clearOnMatch;
	logic       overflowIe;
	logic       compareIe;

	// FTCSR flags
	logic ocfa;
	logic ovf;

	logic frcWrite;
	logic advance;
	logic step;
	logic match;

	always_comb begin
		case (clockSel)
			2'd0:    advance = tick8;
			2'd1:    advance = tick32;
			2'd2:    advance = tick128;
			default: advance = 1'b0;
		endcase
	end

	assign frcWrite = writeEn && regAddr == `FRC_ADDR;
	// A bus write to FRC takes the place of the advance
	assign step  = advance && !frcWrite;
	assign match = frc == ocra;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			frc <= '0;
		end else if (frcWrite) begin
			frc <= writeData;
		end else if (step) begin
			frc <= (match && clearOnMatch) ? '0 : frc + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ocra         <= '1;
			clockSel     <= 2'd0;
			clearOnMatch <= 1'b0;
			overflowIe   <= 1'b0;
			compareIe    <= 1'b0;
		end else if (writeEn) begin
			if (regAddr == `OCRA_ADDR)
				ocra <= writeData;
			if (regAddr == `TCR_ADDR) begin
				clockSel     <= writeData[1:0];
				clearOnMatch <= writeData[2];
				overflowIe   <= writeData[4];
				compareIe    <= writeData[5];
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ocfa <= 1'b0;
			ovf  <= 1'b0;
		end else begin
			// Writing 0 clears, a new event in the same cycle still sets
			if (writeEn && regAddr == `FTCSR_ADDR) begin
				ocfa <= ocfa & writeData[1];
				ovf  <= ovf & writeData[0];
			end
			if (step && match)
				ocfa <= 1'b1;
			if (step && &frc && !(match && clearOnMatch))
				ovf <= 1'b1;
		end
	end

	always_comb begin
		case (regAddr)
			`FRC_ADDR:   readData = frc;
			`OCRA_ADDR:  readData = ocra;
			`FTCSR_ADDR: readData = {14'd0, ocfa, ovf};
			`TCR_ADDR:   readData = {10'd0, compareIe, overflowIe, 1'b0, clearOnMatch, clockSel};
			default:     readData = '0;
		endcase
	end

	assign compareIrq  = ocfa & compareIe;
	assign overflowIrq = ovf & overflowIe;

endmodule

/* timer/intervalTimer.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module intervalTimer (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      writeEn,
	input  periphBusPkg::busAddr_t    regAddr,
	input  periphBusPkg::keyedWrite_t writeData,
	output periphBusPkg::busWord_t    readData,
	input  logic                      tick8,
	input  logic                      tick64,
	input  logic                      tick128,
	input  logic                      tick256,
	input  logic                      tick512,
	input  logic                      tick1024,
	input  logic                      tick4096,
	input  logic                      tick8192,
	output logic                      intervalIrq
);

	logic [7:0] count;
	logic [2:0] clockSel;
	logic       timerEn;
	logic       irqEn;
	logic       ovf;

	logic tick;
	logic step;
	logic cntWrite;
	logic csrWrite;
	periphBusPkg::keyedWrite_t readWord;

	// Writes without the matching key are dropped
	assign cntWrite = writeEn && regAddr == `WTCNT_ADDR && writeData.field.key == `TCNT_KEY;
	assign csrWrite = writeEn && regAddr == `WTCSR_ADDR && writeData.field.key == `TCSR_KEY;

	always_comb begin
		case (clockSel)
			3'd0:    tick = tick8;
			3'd1:    tick = tick64;
			3'd2:    tick = tick128;
			3'd3:    tick = tick256;
			3'd4:    tick = tick512;
			3'd5:    tick = tick1024;
			3'd6:    tick = tick4096;
			default: tick = tick8192;
		endcase
	end

	assign step = timerEn && tick && !cntWrite;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			count <= 8'd0;
		end else if (cntWrite) begin
			count <= writeData.field.value;
		end else if (step) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			clockSel <= 3'd0;
			timerEn  <= 1'b0;
			irqEn    <= 1'b0;
			ovf      <= 1'b0;
		end else begin
			if (csrWrite) begin
				clockSel <= writeData.field.value[2:0];
				timerEn  <= writeData.field.value[5];
				irqEn    <= writeData.field.value[6];
				ovf      <= ovf & writeData.field.value[7];
			end
			// Wrap from 0xFF
			if (step && &count)
				ovf <= 1'b1;
		end
	end

	always_comb begin
		readWord.field.key = 8'h00;
		case (regAddr)
			`WTCNT_ADDR: readWord.field.value = count;
			`WTCSR_ADDR: readWord.field.value = {ovf, irqEn, timerEn, 2'b00, clockSel};
			default:     readWord.field.value = 8'h00;
		endcase
	end

	assign readData    = readWord.raw;
	assign intervalIrq = ovf & irqEn;

endmodule

/* intc/interruptController.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module interruptController (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   writeEn,
	input  periphBusPkg::busAddr_t regAddr,
	input  periphBusPkg::busWord_t writeData,
	output periphBusPkg::busWord_t readData,
	input  logic                   compareIrq,
	input  logic                   overflowIrq,
	input  logic                   intervalIrq,
	output irqPkg::irqLevel_t      irqLevel,
	output irqPkg::irqVector_t     irqVector
);

	// IPR fields
	irqPkg::irqLevel_t   timerPri;
	irqPkg::irqLevel_t   intervalPri;

	// VCR and VCRW fields
	irqPkg::vectorCode_t compareVec;
	irqPkg::vectorCode_t overflowVec;
	irqPkg::vectorCode_t intervalVec;

	irqPkg::irqLevel_t   bestLevel;
	irqPkg::vectorCode_t bestVec;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			timerPri    <= '0;
			intervalPri <= '0;
			compareVec  <= '0;
			overflowVec <= '0;
			intervalVec <= '0;
		end else if (writeEn) begin
			case (regAddr)
				`IPR_ADDR: begin
					timerPri    <= writeData[3:0];
					intervalPri <= writeData[7:4];
				end
				`VCR_ADDR: begin
					compareVec  <= writeData[6:0];
					overflowVec <= writeData[14:8];
				end
				`VCRW_ADDR: intervalVec <= writeData[6:0];
				default: ;
			endcase
		end
	end

	// Interval is looked at first so it keeps a tie, then compare, then overflow
	always_comb begin
		bestLevel = intervalIrq ? intervalPri : '0;
		bestVec   = intervalVec;
		if (compareIrq && timerPri > bestLevel) begin
			bestLevel = timerPri;
			bestVec   = compareVec;
		end
		if (overflowIrq && timerPri > bestLevel) begin
			bestLevel = timerPri;
			bestVec   = overflowVec;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			irqLevel  <= '0;
			irqVector <= '0;
		end else begin
			irqLevel  <= bestLevel;
			irqVector <= (bestLevel != '0) ? {1'b0, bestVec} : '0;
		end
	end

	always_comb begin
		case (regAddr)
			`IPR_ADDR:  readData = {8'd0, intervalPri, timerPri};
			`VCR_ADDR:  readData = {1'b0, overflowVec, 1'b0, compareVec};
			`VCRW_ADDR: readData = {9'd0, intervalVec};
			default:    readData = '0;
		endcase
	end

endmodule

/* logic/periphSubsystem.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module periphSubsystem (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   wbCyc,
	input  logic                   wbStb,
	input  logic                   wbWe,
	input  periphBusPkg::busAddr_t wbAdr,
	input  periphBusPkg::busWord_t wbDatIn,
	output periphBusPkg::busWord_t wbDatOut,
	output logic                   wbAck,
	output irqPkg::irqLevel_t      irqLevel,
	output irqPkg::irqVector_t     irqVector
);

	logic       access;
	logic       writeAccess;
	logic [1:0] blockSel;
	logic       timerWe;
	logic       wdtWe;
	logic       intcWe;

	logic tick8;
	logic tick32;
	logic tick64;
	logic tick128;
	logic tick256;
	logic tick512;
	logic tick1024;
	logic tick4096;
	logic tick8192;

	periphBusPkg::busWord_t timerData;
	periphBusPkg::busWord_t wdtData;
	periphBusPkg::busWord_t intcData;
	periphBusPkg::busWord_t readMux;

	logic compareIrq;
	logic overflowIrq;
	logic intervalIrq;

	// New access is seen in the cycle before ack
	assign access      = wbCyc && wbStb && !wbAck;
	assign writeAccess = access && wbWe;
	assign blockSel    = wbAdr[`ADDR_WIDTH-1 -: 2];

	assign timerWe = writeAccess && blockSel == `TIMER_BLOCK;
	assign wdtWe   = writeAccess && blockSel == `WDT_BLOCK;
	assign intcWe  = writeAccess && blockSel == `INTC_BLOCK;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= access;
		end
	end

	// Unmapped block reads as zero
	always_comb begin
		case (blockSel)
			`TIMER_BLOCK: readMux = timerData;
			`WDT_BLOCK:   readMux = wdtData;
			`INTC_BLOCK:  readMux = intcData;
			default:      readMux = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (access)
			wbDatOut <= readMux;
	end

	clockPrescaler u_clockPrescaler (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.tick8    (tick8),
		.tick32   (tick32),
		.tick64   (tick64),
		.tick128  (tick128),
		.tick256  (tick256),
		.tick512  (tick512),
		.tick1024 (tick1024),
		.tick4096 (tick4096),
		.tick8192 (tick8192)
	);

	freeRunTimer u_freeRunTimer (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.writeEn     (timerWe),
		.regAddr     (wbAdr),
		.writeData   (wbDatIn),
		.readData    (timerData),
		.tick8       (tick8),
		.tick32      (tick32),
		.tick128     (tick128),
		.compareIrq  (compareIrq),
		.overflowIrq (overflowIrq)
	);

	intervalTimer u_intervalTimer (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.writeEn     (wdtWe),
		.regAddr     (wbAdr),
		.writeData   (wbDatIn),
		.readData    (wdtData),
		.tick8       (tick8),
		.tick64      (tick64),
		.tick128     (tick128),
		.tick256     (tick256),
		.tick512     (tick512),
		.tick1024    (tick1024),
		.tick4096    (tick4096),
		.tick8192    (tick8192),
		.intervalIrq (intervalIrq)
	);

	interruptController u_interruptController (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.writeEn     (intcWe),
		.regAddr     (wbAdr),
		.writeData   (wbDatIn),
		.readData    (intcData),
		.compareIrq  (compareIrq),
		.overflowIrq (overflowIrq),
		.intervalIrq (intervalIrq),
		.irqLevel    (irqLevel),
		.irqVector   (irqVector)
	);

endmodule

/* verification/periphSubsystem_assertions.sv */
`timescale 1ns/1ns

module periphSubsystem_assertions (
	input logic               CLK,
	input logic               RST_N,
	input logic               wbCyc,
	input logic               wbStb,
	input logic               wbAck,
	input irqPkg::irqLevel_t  irqLevel,
	input irqPkg::irqVector_t irqVector
);

	// Ack is a single-cycle pulse
	ackOneCycle: assert property (@(posedge CLK) disable iff (!RST_N) wbAck |=> !wbAck)
		else $error("wbAck stayed high for more than one cycle");

	// Ack only while the master holds cyc and stb
	ackInCycle: assert property (@(posedge CLK) disable iff (!RST_N)
		wbAck |-> wbCyc && wbStb)
		else $error("wbAck raised without wbCyc and wbStb");

	vectorBit7Clear: assert property (@(posedge CLK) disable iff (!RST_N)
		irqLevel != 4'd0 |-> !irqVector[7])
		else $error("irqVector bit 7 set with a nonzero level");

endmodule

bind periphSubsystem periphSubsystem_assertions u_assertions (
	.CLK       (CLK),
	.RST_N     (RST_N),
	.wbCyc     (wbCyc),
	.wbStb     (wbStb),
	.wbAck     (wbAck),
	.irqLevel  (irqLevel),
	.irqVector (irqVector)
);

/* verification/periphSubsystemTb.sv */
`timescale 1ns/1ns
`include "periph_settings.svh"

module periphSubsystemTb;

	// Covers three polls of at most 1200 cycles and the remaining bus traffic with wide margin
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int POLL_LIMIT      = 400;

	logic                   CLK;
	logic                   RST_N;
	logic                   wbCyc;
	logic                   wbStb;
	logic                   wbWe;
	periphBusPkg::busAddr_t wbAdr;
	periphBusPkg::busWord_t wbDatIn;
	periphBusPkg::busWord_t wbDatOut;
	logic                   wbAck;
	irqPkg::irqLevel_t      irqLevel;
	irqPkg::irqVector_t     irqVector;

	// One pending check handed to the compare process
	event                   checkEv;
	string                  checkName;
	logic                   checkIsIrq;
	periphBusPkg::busWord_t expWord;
	periphBusPkg::busWord_t gotWord;
	periphBusPkg::busWord_t wordSlack;
	irqPkg::irqLevel_t      expLevel;
	irqPkg::irqLevel_t      gotLevel;
	irqPkg::irqVector_t     expVector;
	irqPkg::irqVector_t     gotVector;
	int                     checksIssued;
	int                     checksDone;

	periphSubsystem u_periphSubsystem (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.wbCyc     (wbCyc),
		.wbStb     (wbStb),
		.wbWe      (wbWe),
		.wbAdr     (wbAdr),
		.wbDatIn   (wbDatIn),
		.wbDatOut  (wbDatOut),
		.wbAck     (wbAck),
		.irqLevel  (irqLevel),
		.irqVector (irqVector)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	// Bits that a register actually holds
	function automatic periphBusPkg::busWord_t refMask(input periphBusPkg::busAddr_t addr);
		case (addr)
			`FRC_ADDR, `OCRA_ADDR: return 16'hFFFF;
			`FTCSR_ADDR:           return 16'h0003;
			`TCR_ADDR:             return 16'h0037;
			`WTCNT_ADDR:           return 16'h00FF;
			`WTCSR_ADDR:           return 16'h00E7;
			`IPR_ADDR:             return 16'h00FF;
			`VCR_ADDR:             return 16'h7F7F;
			`VCRW_ADDR:            return 16'h007F;
			default:               return 16'h0000;
		endcase
	endfunction

	// Highest level wins and ties go to interval, then compare, then overflow
	function automatic logic [11:0] refArbitrate(input logic compareReq, input logic overflowReq,
			input logic intervalReq, input periphBusPkg::busWord_t ipr,
			input periphBusPkg::busWord_t vcr, input periphBusPkg::busWord_t vcrw);
		irqPkg::irqLevel_t  level;
		irqPkg::irqVector_t vector;
		level  = 4'd0;
		vector = 8'd0;
		if (intervalReq && ipr[7:4] != 4'd0) begin
			level  = ipr[7:4];
			vector = {1'b0, vcrw[6:0]};
		end
		if (compareReq && ipr[3:0] > level) begin
			level  = ipr[3:0];
			vector = {1'b0, vcr[6:0]};
		end
		if (overflowReq && ipr[3:0] > level) begin
			level  = ipr[3:0];
			vector = {1'b0, vcr[14:8]};
		end
		return {level, vector};
	endfunction

	task automatic checkWord(input string name, input periphBusPkg::busWord_t expected,
			input periphBusPkg::busWord_t actual, input periphBusPkg::busWord_t slack);
		periphBusPkg::busWord_t diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if (diff > slack)
			abortRun($sformatf("Fail %s expected %h (+/-%0d) actual %h",
				name, expected, slack, actual));
	endtask

	task automatic checkIrq(input string name, input irqPkg::irqLevel_t expectedLevel,
			input irqPkg::irqVector_t expectedVector, input irqPkg::irqLevel_t actualLevel,
			input irqPkg::irqVector_t actualVector);
		if (actualLevel !== expectedLevel || actualVector !== expectedVector)
			abortRun($sformatf("Fail %s expected level %0d vector %h actual level %0d vector %h",
				name, expectedLevel, expectedVector, actualLevel, actualVector));
	endtask

	// Compare process
	initial begin
		checksDone = 0;
		forever begin
			@(checkEv);
			if (checkIsIrq)
				checkIrq(checkName, expLevel, expVector, gotLevel, gotVector);
			else
				checkWord(checkName, expWord, gotWord, wordSlack);
			checksDone++;
		end
	end

	task automatic requestWordCheck(input string name, input periphBusPkg::busWord_t expected,
			input periphBusPkg::busWord_t actual, input periphBusPkg::busWord_t slack);
		checkName  = name;
		checkIsIrq = 1'b0;
		expWord    = expected;
		gotWord    = actual;
		wordSlack  = slack;
		checksIssued++;
		->checkEv;
	endtask

	task automatic requestIrqCheck(input string name, input logic [11:0] expected);
		checkName  = name;
		checkIsIrq = 1'b1;
		expLevel   = expected[11:8];
		expVector  = expected[7:0];
		gotLevel   = irqLevel;
		gotVector  = irqVector;
		checksIssued++;
		->checkEv;
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(posedge CLK);
		#5;
	endtask

	// One Wishbone classic access with ack expected on the first edge
	task automatic busAccess(input logic write, input periphBusPkg::busAddr_t addr,
			input periphBusPkg::busWord_t data, output periphBusPkg::busWord_t readBack);
		int cycles;
		@(posedge CLK);
		#5;
		wbCyc   = 1'b1;
		wbStb   = 1'b1;
		wbWe    = write;
		wbAdr   = addr;
		wbDatIn = data;
		cycles  = 0;
		do begin
			@(posedge CLK);
			#5;
			cycles++;
		end while (!wbAck && cycles < 8);
		if (!wbAck) begin
			abortRun($sformatf("no acknowledge for access to address %0d", addr));
		end else if (cycles != 1) begin
			abortRun($sformatf("access to address %0d acknowledged after %0d cycles", addr, cycles));
		end else begin
			readBack = wbDatOut;
			// Strobe stays up until the edge that samples ack
			@(posedge CLK);
			#5;
			wbCyc    = 1'b0;
			wbStb    = 1'b0;
			wbWe     = 1'b0;
		end
	endtask

	task automatic busWrite(input periphBusPkg::busAddr_t addr, input periphBusPkg::busWord_t data);
		periphBusPkg::busWord_t unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic busRead(input periphBusPkg::busAddr_t addr, output periphBusPkg::busWord_t data);
		busAccess(1'b0, addr, 16'h0000, data);
	endtask

	task automatic waitForFlag(input periphBusPkg::busAddr_t addr, input int bitIndex,
			input string what);
		periphBusPkg::busWord_t data;
		int polls;
		polls = 0;
		busRead(addr, data);
		while (!data[bitIndex] && polls < POLL_LIMIT) begin
			busRead(addr, data);
			polls++;
		end
		if (!data[bitIndex])
			abortRun($sformatf("%s flag was never set", what));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		abortRun($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		periphBusPkg::busAddr_t    regList [5];
		periphBusPkg::busWord_t    rd;
		periphBusPkg::busWord_t    wordVal;
		periphBusPkg::busWord_t    iprVal;
		periphBusPkg::busWord_t    vcrVal;
		periphBusPkg::busWord_t    vcrwVal;
		periphBusPkg::keyedWrite_t kw;
		irqPkg::irqLevel_t         timerPri;
		irqPkg::irqLevel_t         intervalPri;

		void'($urandom(32'h7321_4ec2));
		RST_N        = 1'b0;
		wbCyc        = 1'b0;
		wbStb        = 1'b0;
		wbWe         = 1'b0;
		wbAdr        = '0;
		wbDatIn      = '0;
		checksIssued = 0;
		repeat (3) @(posedge CLK);
		#5;
		RST_N = 1'b1;

		// Register read-back
		regList = '{`OCRA_ADDR, `TCR_ADDR, `IPR_ADDR, `VCR_ADDR, `VCRW_ADDR};
		foreach (regList[i]) begin
			wordVal = 16'($urandom);
			busWrite(regList[i], wordVal);
			busRead(regList[i], rd);
			requestWordCheck($sformatf("readback of register %0d", regList[i]),
				wordVal & refMask(regList[i]), rd, 16'd0);
		end
		busWrite(4'd5, 16'($urandom));
		busRead(4'd5, rd);
		requestWordCheck("unmapped address 5", 16'h0000, rd, 16'd0);
		busRead(4'd15, rd);
		requestWordCheck("unmapped address 15", 16'h0000, rd, 16'd0);

		// Keyed writes with a nonzero WTCSR value that keeps the counter disabled
		kw.field.key   = `TCNT_KEY;
		kw.field.value = (8'($urandom) & 8'h47) | 8'h40;
		busWrite(`WTCSR_ADDR, kw.raw);
		busRead(`WTCSR_ADDR, rd);
		requestWordCheck("WTCSR with wrong key", 16'h0000, rd, 16'd0);
		kw.field.key = `TCSR_KEY;
		busWrite(`WTCSR_ADDR, kw.raw);
		busRead(`WTCSR_ADDR, rd);
		requestWordCheck("WTCSR with key", {8'h00, kw.field.value}, rd, 16'd0);
		kw.field.value = 8'd1 + 8'($urandom % 255);
		busWrite(`WTCNT_ADDR, kw.raw);
		busRead(`WTCNT_ADDR, rd);
		requestWordCheck("WTCNT with wrong key", 16'h0000, rd, 16'd0);
		kw.field.key = `TCNT_KEY;
		busWrite(`WTCNT_ADDR, kw.raw);
		busRead(`WTCNT_ADDR, rd);
		requestWordCheck("WTCNT with key", {8'h00, kw.field.value}, rd, 16'd0);

		// FRC advance at divide by 8
		busWrite(`TCR_ADDR, 16'h0000);
		busWrite(`FRC_ADDR, 16'h0000);
		repeat (200) @(posedge CLK);
		busRead(`FRC_ADDR, rd);
		requestWordCheck("FRC after 200 cycles", 16'd200 / 16'd8, rd, 16'd1);

		// Compare match with clear and interrupt
		iprVal       = 16'($urandom) & 16'h00FF;
		iprVal[3:0]  = 4'd1 + 4'($urandom % 15);
		vcrVal       = 16'($urandom) & 16'h7F7F;
		vcrwVal      = 16'($urandom) & 16'h007F;
		// Distinct vectors so that a tie shows which request won
		if (vcrwVal[6:0] == vcrVal[6:0])
			vcrwVal[0] = ~vcrwVal[0];
		busWrite(`IPR_ADDR, iprVal);
		busWrite(`VCR_ADDR, vcrVal);
		busWrite(`VCRW_ADDR, vcrwVal);
		busWrite(`TCR_ADDR, 16'h0007);
		busWrite(`OCRA_ADDR, 16'd20);
		busWrite(`FRC_ADDR, 16'h0000);
		busWrite(`FTCSR_ADDR, 16'h0000);
		busWrite(`TCR_ADDR, 16'h0024);
		waitForFlag(`FTCSR_ADDR, 1, "compare match");
		busWrite(`TCR_ADDR, 16'h0027);
		busRead(`FTCSR_ADDR, rd);
		requestWordCheck("FTCSR after match", 16'h0002, rd, 16'd0);
		waitCycles(2);
		requestIrqCheck("compare request",
			refArbitrate(1'b1, 1'b0, 1'b0, iprVal, vcrVal, vcrwVal));
		busWrite(`FTCSR_ADDR, 16'h0000);
		waitCycles(2);
		requestIrqCheck("compare cleared",
			refArbitrate(1'b0, 1'b0, 1'b0, iprVal, vcrVal, vcrwVal));

		// Interval overflow and then a stop that keeps the flag
		kw.field.key   = `TCNT_KEY;
		kw.field.value = 8'hF0;
		busWrite(`WTCNT_ADDR, kw.raw);
		kw.field.key   = `TCSR_KEY;
		kw.field.value = 8'h60;
		busWrite(`WTCSR_ADDR, kw.raw);
		waitForFlag(`WTCSR_ADDR, 7, "interval overflow");
		kw.field.value = 8'hC0;
		busWrite(`WTCSR_ADDR, kw.raw);
		busWrite(`FRC_ADDR, 16'h0000);
		busWrite(`OCRA_ADDR, 16'd2);
		busWrite(`TCR_ADDR, 16'h0024);
		waitForFlag(`FTCSR_ADDR, 1, "second compare match");
		busWrite(`TCR_ADDR, 16'h0027);

		// Different levels
		timerPri    = 4'd1 + 4'($urandom % 15);
		intervalPri = 4'd1 + 4'($urandom % 15);
		if (intervalPri == timerPri)
			intervalPri = (timerPri == 4'd15) ? 4'd14 : timerPri + 4'd1;
		iprVal = {8'h00, intervalPri, timerPri};
		busWrite(`IPR_ADDR, iprVal);
		waitCycles(2);
		requestIrqCheck("different levels",
			refArbitrate(1'b1, 1'b0, 1'b1, iprVal, vcrVal, vcrwVal));

		// Equal levels go to the interval timer
		iprVal = {8'h00, timerPri, timerPri};
		busWrite(`IPR_ADDR, iprVal);
		waitCycles(2);
		requestIrqCheck("equal levels",
			refArbitrate(1'b1, 1'b0, 1'b1, iprVal, vcrVal, vcrwVal));

		waitCycles(2);
		if (checksIssued > 0 && checksDone == checksIssued) begin
			$display("Everything OK");
			$finish;
		end else begin
			abortRun($sformatf("only %0d of %0d checks were compared", checksDone, checksIssued));
		end
	end

endmodule

/* periphSubsystem.f */
+incdir+common
common/periphBusPkg.sv
common/irqPkg.sv
logic/clockPrescaler.sv
timer/freeRunTimer.sv
timer/intervalTimer.sv
intc/interruptController.sv
logic/periphSubsystem.sv
verification/periphSubsystem_assertions.sv
verification/periphSubsystemTb.sv

/* Bender.yml */
package:
  name: periphSubsystem

sources:
  - include_dirs:
      - common
    files:
      - common/periphBusPkg.sv
      - common/irqPkg.sv
      - logic/clockPrescaler.sv
      - timer/freeRunTimer.sv
      - timer/intervalTimer.sv
      - intc/interruptController.sv
      - logic/periphSubsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/periphSubsystem_assertions.sv
      - verification/periphSubsystemTb.sv
